// File: source/la_cfg.svh
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

// data path width
`define LA_XLEN 32

// general purpose register count
`define LA_NREG 32

// register index width
`define LA_RADDR_W 5

`endif

// File: source/la_pkg.sv
`include "la_cfg.svh"

package la_pkg;

    typedef logic [`LA_XLEN-1:0] xlen_t;
    typedef logic [`LA_RADDR_W-1:0] reg_idx_t;

    //////////////////////////////////////////////////
    // instruction formats
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm20;
        reg_idx_t    rd;
    } inst_1ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_2ri16_t;

    // offs[15:0] sits above offs[25:16]
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_i26_t;

    typedef union packed {
        inst_3r_t    fmt_3r;
        inst_2ri12_t fmt_2ri12;
        inst_1ri20_t fmt_1ri20;
        inst_2ri16_t fmt_2ri16;
        inst_i26_t   fmt_i26;
    } inst_word_u;

    //////////////////////////////////////////////////
    // execute controls
    //////////////////////////////////////////////////

    // one-hot alu op, bit positions
    typedef logic [10:0] alu_op_t;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_NOR  = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JIRL = 4'd3,
        BR_B    = 4'd4,
        BR_BL   = 4'd5,
        BR_BEQ  = 4'd6,
        BR_BNE  = 4'd7,
        BR_BLT  = 4'd8,
        BR_BGE  = 4'd9,
        BR_BLTU = 4'd10,
        BR_BGEU = 4'd11
    } br_type_e;

    typedef enum logic [1:0] {SRC1_RJ, SRC1_PC, SRC1_ZERO} src1_sel_e;
    typedef enum logic [1:0] {SRC2_RK, SRC2_IMM, SRC2_FOUR} src2_sel_e;

endpackage

// File: source/ex_bus_if.sv
`timescale 1ns/1ps

interface ex_bus_if;

    la_pkg::xlen_t     pc;
    la_pkg::alu_op_t   alu_op;
    la_pkg::br_type_e  br_type;
    la_pkg::src1_sel_e src1_sel;
    la_pkg::src2_sel_e src2_sel;
    la_pkg::xlen_t     imm;
    la_pkg::reg_idx_t  rj;
    // rd for branches and stores, rk otherwise
    la_pkg::reg_idx_t  rk_or_rd;
    la_pkg::reg_idx_t  rd;
    logic              we;

    modport dec (
        output pc, alu_op, br_type, src1_sel, src2_sel,
        output imm, rj, rk_or_rd, rd, we
    );

    modport exe (
        input pc, alu_op, br_type, src1_sel, src2_sel,
        input imm, rj, rk_or_rd, rd, we
    );

endinterface

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  la_pkg::inst_word_u i_inst,
    input  la_pkg::xlen_t      i_pc,
    output logic               o_lawful,
    ex_bus_if.dec              ex_bus
);

    logic add_hit, sub_hit, slt_hit, sltu_hit;
    logic and_hit, or_hit, nor_hit, xor_hit;
    logic sll_hit, srl_hit, sra_hit;
    logic slli_hit, srli_hit, srai_hit;
    logic addi_hit, slti_hit, sltui_hit;
    logic andi_hit, ori_hit, xori_hit;
    logic lu12i_hit, pcaddu12i_hit;
    logic beq_hit, bne_hit, blt_hit, bge_hit, bltu_hit, bgeu_hit;
    logic b_hit, bl_hit, jirl_hit;
    logic store_hit;

    // format groups
    logic r3_alu, imm_s12, imm_z12, imm_sh, imm_u20, br_cond;
    la_pkg::reg_idx_t rd_idx;

    //////////////////////////////////////////////////
    // opcode match
    //////////////////////////////////////////////////

    assign add_hit   = (i_inst.fmt_3r.opcode == 17'h00020);
    assign sub_hit   = (i_inst.fmt_3r.opcode == 17'h00022);
    assign slt_hit   = (i_inst.fmt_3r.opcode == 17'h00024);
    assign sltu_hit  = (i_inst.fmt_3r.opcode == 17'h00025);
    assign nor_hit   = (i_inst.fmt_3r.opcode == 17'h00028);
    assign and_hit   = (i_inst.fmt_3r.opcode == 17'h00029);
    assign or_hit    = (i_inst.fmt_3r.opcode == 17'h0002a);
    assign xor_hit   = (i_inst.fmt_3r.opcode == 17'h0002b);
    assign sll_hit   = (i_inst.fmt_3r.opcode == 17'h0002e);
    assign srl_hit   = (i_inst.fmt_3r.opcode == 17'h0002f);
    assign sra_hit   = (i_inst.fmt_3r.opcode == 17'h00030);
    // shift-by-immediate keeps ui5 in the rk slot
    assign slli_hit  = (i_inst.fmt_3r.opcode == 17'h00081);
    assign srli_hit  = (i_inst.fmt_3r.opcode == 17'h00089);
    assign srai_hit  = (i_inst.fmt_3r.opcode == 17'h00091);

    assign slti_hit  = (i_inst.fmt_2ri12.opcode == 10'h008);
    assign sltui_hit = (i_inst.fmt_2ri12.opcode == 10'h009);
    assign addi_hit  = (i_inst.fmt_2ri12.opcode == 10'h00a);
    assign andi_hit  = (i_inst.fmt_2ri12.opcode == 10'h00d);
    assign ori_hit   = (i_inst.fmt_2ri12.opcode == 10'h00e);
    assign xori_hit  = (i_inst.fmt_2ri12.opcode == 10'h00f);
    // st.b, st.h, st.w only steer the second read port
    assign store_hit = (i_inst.fmt_2ri12.opcode inside {10'h0a4, 10'h0a5, 10'h0a6});

    assign lu12i_hit     = (i_inst.fmt_1ri20.opcode == 7'h0a);
    assign pcaddu12i_hit = (i_inst.fmt_1ri20.opcode == 7'h0e);

    assign jirl_hit = (i_inst.fmt_2ri16.opcode == 6'h13);
    assign b_hit    = (i_inst.fmt_i26.opcode == 6'h14);
    assign bl_hit   = (i_inst.fmt_i26.opcode == 6'h15);
    assign beq_hit  = (i_inst.fmt_2ri16.opcode == 6'h16);
    assign bne_hit  = (i_inst.fmt_2ri16.opcode == 6'h17);
    assign blt_hit  = (i_inst.fmt_2ri16.opcode == 6'h18);
    assign bge_hit  = (i_inst.fmt_2ri16.opcode == 6'h19);
    assign bltu_hit = (i_inst.fmt_2ri16.opcode == 6'h1a);
    assign bgeu_hit = (i_inst.fmt_2ri16.opcode == 6'h1b);

    assign r3_alu  = add_hit | sub_hit | slt_hit | sltu_hit | and_hit | or_hit
                   | nor_hit | xor_hit | sll_hit | srl_hit | sra_hit;
    assign imm_s12 = addi_hit | slti_hit | sltui_hit;
    assign imm_z12 = andi_hit | ori_hit | xori_hit;
    assign imm_sh  = slli_hit | srli_hit | srai_hit;
    assign imm_u20 = lu12i_hit | pcaddu12i_hit;
    assign br_cond = beq_hit | bne_hit | blt_hit | bge_hit | bltu_hit | bgeu_hit;

    // loads, stores, mul/div and csr all land here as unlawful
    assign o_lawful = r3_alu | imm_s12 | imm_z12 | imm_sh | imm_u20 | br_cond
                    | b_hit | bl_hit | jirl_hit;

    //////////////////////////////////////////////////
    // bundle fields
    //////////////////////////////////////////////////

    always_comb begin
        if (imm_s12)
            ex_bus.imm = {{20{i_inst.fmt_2ri12.imm12[11]}}, i_inst.fmt_2ri12.imm12};
        else if (imm_z12)
            ex_bus.imm = {20'd0, i_inst.fmt_2ri12.imm12};
        else if (imm_sh)
            ex_bus.imm = {27'd0, i_inst.fmt_3r.rk};
        else if (imm_u20)
            ex_bus.imm = {i_inst.fmt_1ri20.imm20, 12'd0};
        else if (br_cond | jirl_hit)
            ex_bus.imm = {{14{i_inst.fmt_2ri16.offs16[15]}}, i_inst.fmt_2ri16.offs16, 2'b00};
        else if (b_hit | bl_hit)
            ex_bus.imm = {{4{i_inst.fmt_i26.offs_hi[9]}}, i_inst.fmt_i26.offs_hi,
                          i_inst.fmt_i26.offs_lo, 2'b00};
        else
            ex_bus.imm = '0;
    end

    always_comb begin
        ex_bus.alu_op = '0;
        ex_bus.alu_op[la_pkg::ALU_ADD]  = add_hit | addi_hit | imm_u20 | b_hit | bl_hit | jirl_hit;
        ex_bus.alu_op[la_pkg::ALU_SUB]  = sub_hit | beq_hit | bne_hit;
        ex_bus.alu_op[la_pkg::ALU_SLT]  = slt_hit | slti_hit | blt_hit | bge_hit;
        ex_bus.alu_op[la_pkg::ALU_SLTU] = sltu_hit | sltui_hit | bltu_hit | bgeu_hit;
        ex_bus.alu_op[la_pkg::ALU_AND]  = and_hit | andi_hit;
        ex_bus.alu_op[la_pkg::ALU_OR]   = or_hit | ori_hit;
        ex_bus.alu_op[la_pkg::ALU_NOR]  = nor_hit;
        ex_bus.alu_op[la_pkg::ALU_XOR]  = xor_hit | xori_hit;
        ex_bus.alu_op[la_pkg::ALU_SLL]  = sll_hit | slli_hit;
        ex_bus.alu_op[la_pkg::ALU_SRL]  = srl_hit | srli_hit;
        ex_bus.alu_op[la_pkg::ALU_SRA]  = sra_hit | srai_hit;
    end

    always_comb begin
        if (beq_hit)       ex_bus.br_type = la_pkg::BR_BEQ;
        else if (bne_hit)  ex_bus.br_type = la_pkg::BR_BNE;
        else if (blt_hit)  ex_bus.br_type = la_pkg::BR_BLT;
        else if (bge_hit)  ex_bus.br_type = la_pkg::BR_BGE;
        else if (bltu_hit) ex_bus.br_type = la_pkg::BR_BLTU;
        else if (bgeu_hit) ex_bus.br_type = la_pkg::BR_BGEU;
        else if (b_hit)    ex_bus.br_type = la_pkg::BR_B;
        else if (bl_hit)   ex_bus.br_type = la_pkg::BR_BL;
        else if (jirl_hit) ex_bus.br_type = la_pkg::BR_JIRL;
        else               ex_bus.br_type = la_pkg::BR_NONE;
    end

    // jumps run pc + 4 through the alu for the link value
    always_comb begin
        if (b_hit | bl_hit | jirl_hit | pcaddu12i_hit)
            ex_bus.src1_sel = la_pkg::SRC1_PC;
        else if (lu12i_hit)
            ex_bus.src1_sel = la_pkg::SRC1_ZERO;
        else
            ex_bus.src1_sel = la_pkg::SRC1_RJ;
        if (imm_s12 | imm_z12 | imm_sh | imm_u20)
            ex_bus.src2_sel = la_pkg::SRC2_IMM;
        else if (b_hit | bl_hit | jirl_hit)
            ex_bus.src2_sel = la_pkg::SRC2_FOUR;
        else
            ex_bus.src2_sel = la_pkg::SRC2_RK;
    end

    assign rd_idx          = bl_hit ? la_pkg::reg_idx_t'(1) : i_inst.fmt_3r.rd;
    assign ex_bus.pc       = i_pc;
    assign ex_bus.rj       = i_inst.fmt_3r.rj;
    assign ex_bus.rk_or_rd = (store_hit | br_cond) ? i_inst.fmt_3r.rd : i_inst.fmt_3r.rk;
    assign ex_bus.rd       = rd_idx;
    // r0 never gets a live we, so bypass needs no r0 check
    assign ex_bus.we       = (rd_idx != '0) & ~(br_cond | b_hit) & ~store_hit;

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

`include "la_cfg.svh"

module reg_file (
    input  logic             i_clk,
    input  logic             i_reset,
    input  la_pkg::reg_idx_t i_raddr1,
    input  la_pkg::reg_idx_t i_raddr2,
    output la_pkg::xlen_t    o_rdata1,
    output la_pkg::xlen_t    o_rdata2,
    input  logic             i_we,
    input  la_pkg::reg_idx_t i_waddr,
    input  la_pkg::xlen_t    i_wdata
);

    la_pkg::xlen_t regs [`LA_NREG];

    // r0 stays at its reset value
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `LA_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // no internal bypass, the execute stage handles it
    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  la_pkg::alu_op_t i_op,
    input  la_pkg::xlen_t   i_a,
    input  la_pkg::xlen_t   i_b,
    output la_pkg::xlen_t   o_result
);

    la_pkg::xlen_t sum;
    la_pkg::xlen_t diff;
    logic [4:0]    shamt;
    logic          lt_s;
    logic          lt_u;

    assign sum   = i_a + i_b;
    assign diff  = i_a - i_b;
    assign shamt = i_b[4:0];
    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;

    // op is one-hot; an all-zero op gives zero
    always_comb begin
        case (1'b1)
            i_op[la_pkg::ALU_ADD]:  o_result = sum;
            i_op[la_pkg::ALU_SUB]:  o_result = diff;
            i_op[la_pkg::ALU_SLT]:  o_result = {31'd0, lt_s};
            i_op[la_pkg::ALU_SLTU]: o_result = {31'd0, lt_u};
            i_op[la_pkg::ALU_AND]:  o_result = i_a & i_b;
            i_op[la_pkg::ALU_OR]:   o_result = i_a | i_b;
            i_op[la_pkg::ALU_NOR]:  o_result = ~(i_a | i_b);
            i_op[la_pkg::ALU_XOR]:  o_result = i_a ^ i_b;
            i_op[la_pkg::ALU_SLL]:  o_result = i_a << shamt;
            i_op[la_pkg::ALU_SRL]:  o_result = i_a >> shamt;
            i_op[la_pkg::ALU_SRA]:  o_result = la_pkg::xlen_t'($signed(i_a) >>> shamt);
            default:                o_result = '0;
        endcase
    end

endmodule

// File: source/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  logic             i_lawful,
    ex_bus_if.exe            ex_bus,
    input  logic             i_ex_redirect,
    input  la_pkg::reg_idx_t i_ex_rd,
    input  logic             i_ex_we,
    output logic             o_ex_load,
    output logic             o_fwd1,
    output logic             o_fwd2,
    output logic             o_illegal
);

    logic accept;

    // a taken branch in execute kills the word now at the input
    assign accept    = i_valid & ~i_ex_redirect;
    assign o_ex_load = accept & i_lawful;

    // illegal pulse shares the result slot timing of the execute stage
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_illegal <= 1'b0;
        end else begin
            o_illegal <= accept & ~i_lawful;
        end
    end

    //////////////////////////////////////////////////
    // bypass from the instruction in execute
    //////////////////////////////////////////////////

    // i_ex_we already includes stage valid and rd != r0
    assign o_fwd1 = i_ex_we & (ex_bus.rj == i_ex_rd);
    assign o_fwd2 = i_ex_we & (ex_bus.rk_or_rd == i_ex_rd);

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_load,
    input  logic             i_fwd1,
    input  logic             i_fwd2,
    input  la_pkg::xlen_t    i_rdata1,
    input  la_pkg::xlen_t    i_rdata2,
    ex_bus_if.exe            ex_bus,
    output la_pkg::xlen_t    o_alu_a,
    output la_pkg::xlen_t    o_alu_b,
    output la_pkg::alu_op_t  o_alu_op,
    input  la_pkg::xlen_t    i_alu_result,
    output logic             o_redirect,
    output la_pkg::xlen_t    o_redirect_pc,
    output la_pkg::reg_idx_t o_ex_rd,
    output logic             o_ex_we,
    output logic             o_wb_valid,
    output la_pkg::reg_idx_t o_wb_rd,
    output la_pkg::xlen_t    o_wb_data
);

    logic              ex_valid;
    la_pkg::xlen_t     ex_pc;
    la_pkg::alu_op_t   ex_alu_op;
    la_pkg::br_type_e  ex_br_type;
    la_pkg::src1_sel_e ex_src1_sel;
    la_pkg::src2_sel_e ex_src2_sel;
    la_pkg::xlen_t     ex_imm;
    la_pkg::reg_idx_t  ex_rd;
    logic              ex_we;
    la_pkg::xlen_t     ex_op1;
    la_pkg::xlen_t     ex_op2;
    logic              taken;
    la_pkg::xlen_t     target_base;

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= i_load;
        end
    end

    // operands pick up the result still in flight
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            ex_pc       <= ex_bus.pc;
            ex_alu_op   <= ex_bus.alu_op;
            ex_br_type  <= ex_bus.br_type;
            ex_src1_sel <= ex_bus.src1_sel;
            ex_src2_sel <= ex_bus.src2_sel;
            ex_imm      <= ex_bus.imm;
            ex_rd       <= ex_bus.rd;
            ex_we       <= ex_bus.we;
            ex_op1      <= i_fwd1 ? i_alu_result : i_rdata1;
            ex_op2      <= i_fwd2 ? i_alu_result : i_rdata2;
        end
    end

    always_comb begin
        case (ex_src1_sel)
            la_pkg::SRC1_PC:   o_alu_a = ex_pc;
            la_pkg::SRC1_ZERO: o_alu_a = '0;
            default:           o_alu_a = ex_op1;
        endcase
        case (ex_src2_sel)
            la_pkg::SRC2_IMM:  o_alu_b = ex_imm;
            la_pkg::SRC2_FOUR: o_alu_b = 32'd4;
            default:           o_alu_b = ex_op2;
        endcase
    end

    assign o_alu_op = ex_alu_op;

    //////////////////////////////////////////////////
    // branch resolve
    //////////////////////////////////////////////////

    // compares come from sub, slt or sltu in the alu
    always_comb begin
        case (ex_br_type)
            la_pkg::BR_JIRL, la_pkg::BR_B, la_pkg::BR_BL: taken = 1'b1;
            la_pkg::BR_BEQ:                  taken = (i_alu_result == '0);
            la_pkg::BR_BNE:                  taken = (i_alu_result != '0);
            la_pkg::BR_BLT, la_pkg::BR_BLTU: taken = i_alu_result[0];
            la_pkg::BR_BGE, la_pkg::BR_BGEU: taken = ~i_alu_result[0];
            default:                         taken = 1'b0;
        endcase
    end

    assign target_base   = (ex_br_type == la_pkg::BR_JIRL) ? ex_op1 : ex_pc;
    assign o_redirect_pc = target_base + ex_imm;
    assign o_redirect    = ex_valid & taken;

    // link value pc + 4 also comes out of the alu
    assign o_ex_rd    = ex_rd;
    assign o_ex_we    = ex_valid & ex_we;
    assign o_wb_valid = ex_valid & ex_we;
    assign o_wb_rd    = ex_rd;
    assign o_wb_data  = i_alu_result;

endmodule

// File: source/la_core_top.sv
`timescale 1ns/1ps

module la_core_top (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  la_pkg::xlen_t    i_inst,
    input  la_pkg::xlen_t    i_pc,
    output logic             o_wb_valid,
    output la_pkg::reg_idx_t o_wb_rd,
    output la_pkg::xlen_t    o_wb_data,
    output logic             o_redirect,
    output la_pkg::xlen_t    o_redirect_pc,
    output logic             o_illegal
);

    logic             lawful;
    logic             ex_load;
    logic             fwd1;
    logic             fwd2;
    logic             ex_we;
    la_pkg::reg_idx_t ex_rd;
    la_pkg::xlen_t    rdata1;
    la_pkg::xlen_t    rdata2;
    la_pkg::xlen_t    alu_a;
    la_pkg::xlen_t    alu_b;
    la_pkg::alu_op_t  alu_op;
    la_pkg::xlen_t    alu_result;

    ex_bus_if ex_bus ();

    //////////////////////////////////////////////////
    // decode and register read
    //////////////////////////////////////////////////

    inst_decoder u_dec (
        .i_inst   (i_inst),
        .i_pc     (i_pc),
        .o_lawful (lawful),
        .ex_bus   (ex_bus.dec)
    );

    reg_file u_rf (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_raddr1 (ex_bus.rj),
        .i_raddr2 (ex_bus.rk_or_rd),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2),
        .i_we     (o_wb_valid),
        .i_waddr  (o_wb_rd),
        .i_wdata  (o_wb_data)
    );

    pipe_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_lawful      (lawful),
        .ex_bus        (ex_bus.exe),
        .i_ex_redirect (o_redirect),
        .i_ex_rd       (ex_rd),
        .i_ex_we       (ex_we),
        .o_ex_load     (ex_load),
        .o_fwd1        (fwd1),
        .o_fwd2        (fwd2),
        .o_illegal     (o_illegal)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////

    exec_unit u_exe (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_load        (ex_load),
        .i_fwd1        (fwd1),
        .i_fwd2        (fwd2),
        .i_rdata1      (rdata1),
        .i_rdata2      (rdata2),
        .ex_bus        (ex_bus.exe),
        .o_alu_a       (alu_a),
        .o_alu_b       (alu_b),
        .o_alu_op      (alu_op),
        .i_alu_result  (alu_result),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_ex_rd       (ex_rd),
        .o_ex_we       (ex_we),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

endmodule

// File: bench/la_core_sva.sv
`timescale 1ns/1ps

module la_core_sva (
    input logic             i_clk,
    input logic             i_reset,
    input logic             o_wb_valid,
    input la_pkg::reg_idx_t o_wb_rd,
    input logic             o_redirect,
    input logic             o_illegal
);

    // link jumps raise writeback and redirect in the same slot
    a_one_result: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot0({o_illegal, o_wb_valid | o_redirect})
    ) else $error("more than one result kind in one cycle");

    // outputs clear on the first reset edge and stay low
    a_quiet_in_reset: assert property (
        @(posedge i_clk)
        i_reset |=> (!o_wb_valid && !o_redirect && !o_illegal)
    ) else $error("result output high during reset");

    a_no_r0_write: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb_valid |-> (o_wb_rd != '0)
    ) else $error("writeback to r0");

endmodule

bind la_core_top la_core_sva u_sva (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_redirect (o_redirect),
    .o_illegal  (o_illegal)
);

// File: bench/la_core_tb.sv
`timescale 1ns/1ps

module la_core_tb;

    localparam logic [31:0] BASE_PC = 32'h1c00_0000;
    localparam int MAX_ENTRIES = 80;
    localparam int K_NONE = 0;
    localparam int K_WB   = 1;
    localparam int K_BR   = 2;
    localparam int K_LINK = 3;
    localparam int K_ILL  = 4;

    logic             i_clk;
    logic             i_reset;
    logic             i_valid;
    la_pkg::xlen_t    i_inst;
    la_pkg::xlen_t    i_pc;
    logic             o_wb_valid;
    la_pkg::reg_idx_t o_wb_rd;
    la_pkg::xlen_t    o_wb_data;
    logic             o_redirect;
    la_pkg::xlen_t    o_redirect_pc;
    logic             o_illegal;

    // stimulus and expected result table
    la_pkg::xlen_t    tbl_inst   [MAX_ENTRIES];
    la_pkg::xlen_t    tbl_pc     [MAX_ENTRIES];
    int               tbl_kind   [MAX_ENTRIES];
    la_pkg::reg_idx_t tbl_rd     [MAX_ENTRIES];
    la_pkg::xlen_t    tbl_data   [MAX_ENTRIES];
    la_pkg::xlen_t    tbl_target [MAX_ENTRIES];
    int               n_entries;
    int               check_errors;
    int               timeout_errors;
    int               cycles;
    int               cycle_limit;

    la_core_top dut0 (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_illegal     (o_illegal)
    );

    always #20 i_clk = ~i_clk;

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    function automatic la_pkg::xlen_t r3(logic [16:0] op, logic [4:0] rk, logic [4:0] rj,
                                         logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic la_pkg::xlen_t ri12(logic [9:0] op, logic [11:0] imm, logic [4:0] rj,
                                           logic [4:0] rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic la_pkg::xlen_t ri20(logic [6:0] op, logic [19:0] imm, logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic la_pkg::xlen_t ri16(logic [5:0] op, logic [15:0] offs, logic [4:0] rj,
                                           logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    // low offset half sits above the high part
    function automatic la_pkg::xlen_t i26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic add_entry(input la_pkg::xlen_t inst, input int kind,
                             input la_pkg::reg_idx_t rd, input la_pkg::xlen_t data,
                             input la_pkg::xlen_t target);
        tbl_inst[n_entries]   = inst;
        tbl_pc[n_entries]     = BASE_PC + 32'(4 * n_entries);
        tbl_kind[n_entries]   = kind;
        tbl_rd[n_entries]     = rd;
        tbl_data[n_entries]   = data;
        tbl_target[n_entries] = target;
        n_entries++;
    endtask

    task automatic build_table();
        la_pkg::xlen_t squash_word;
        squash_word = ri12(10'h00a, 12'h001, 5'd0, 5'd20);
        n_entries = 0;
        // every register reads zero after reset
        // each entry writes back only the rk it has just read
        for (int i = 0; i < 16; i++) begin
            add_entry(r3(17'h2a, 5'(2 * i + 1), 5'(2 * i), 5'(2 * i + 1)), K_WB,
                      5'(2 * i + 1), 32'h0, 32'h0);
        end
        add_entry(ri12(10'h00a, 12'hffb, 5'd0, 5'd4), K_WB, 5'd4, 32'hffff_fffb, 0);
        add_entry(ri12(10'h00e, 12'h8f0, 5'd0, 5'd5), K_WB, 5'd5, 32'h0000_08f0, 0);
        add_entry(ri20(7'h0a, 20'h80001, 5'd6), K_WB, 5'd6, 32'h8000_1000, 0);
        add_entry(ri20(7'h0e, 20'h00002, 5'd7), K_WB, 5'd7, 32'h1c00_204c, 0);
        add_entry(r3(17'h81, 5'd4, 5'd5, 5'd8), K_WB, 5'd8, 32'h0000_8f00, 0);
        add_entry(r3(17'h89, 5'd8, 5'd6, 5'd9), K_WB, 5'd9, 32'h0080_0010, 0);
        add_entry(r3(17'h91, 5'd8, 5'd6, 5'd10), K_WB, 5'd10, 32'hff80_0010, 0);
        // back-to-back bypass on rj then rk
        add_entry(r3(17'h20, 5'd5, 5'd4, 5'd11), K_WB, 5'd11, 32'h0000_08eb, 0);
        add_entry(r3(17'h22, 5'd5, 5'd11, 5'd12), K_WB, 5'd12, 32'hffff_fffb, 0);
        add_entry(r3(17'h22, 5'd12, 5'd6, 5'd13), K_WB, 5'd13, 32'h8000_1005, 0);
        add_entry(r3(17'h24, 5'd5, 5'd4, 5'd14), K_WB, 5'd14, 32'h1, 0);
        add_entry(r3(17'h25, 5'd5, 5'd4, 5'd15), K_WB, 5'd15, 32'h0, 0);
        ////////////////////////////////////////////////
        // conditional branches, r4 = -5, r5 = 0x8f0
        ////////////////////////////////////////////////
        add_entry(ri16(6'h16, 16'h0002, 5'd4, 5'd5), K_NONE, 0, 0, 0);
        add_entry(ri16(6'h16, 16'h0004, 5'd5, 5'd5), K_BR, 0, 0, BASE_PC + 32'h84);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h17, 16'h0003, 5'd4, 5'd5), K_BR, 0, 0, BASE_PC + 32'h88);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h17, 16'h0003, 5'd5, 5'd5), K_NONE, 0, 0, 0);
        add_entry(ri16(6'h18, 16'hfffe, 5'd4, 5'd5), K_BR, 0, 0, BASE_PC + 32'h80);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h18, 16'hfffe, 5'd5, 5'd4), K_NONE, 0, 0, 0);
        add_entry(ri16(6'h19, 16'h0005, 5'd5, 5'd4), K_BR, 0, 0, BASE_PC + 32'ha8);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h19, 16'h0005, 5'd4, 5'd5), K_NONE, 0, 0, 0);
        add_entry(ri16(6'h1a, 16'h0001, 5'd5, 5'd4), K_BR, 0, 0, BASE_PC + 32'ha4);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h1a, 16'h0001, 5'd4, 5'd5), K_NONE, 0, 0, 0);
        add_entry(ri16(6'h1b, 16'h0002, 5'd4, 5'd5), K_BR, 0, 0, BASE_PC + 32'hb4);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h1b, 16'h0002, 5'd5, 5'd4), K_NONE, 0, 0, 0);
        // jumps with and without link
        add_entry(i26(6'h15, 26'h100), K_LINK, 5'd1, BASE_PC + 32'hbc, BASE_PC + 32'h4b8);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(ri16(6'h13, 16'h0004, 5'd6, 5'd3), K_LINK, 5'd3, BASE_PC + 32'hc4,
                  32'h8000_1010);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        add_entry(i26(6'h14, 26'h3ff_ffff), K_BR, 0, 0, BASE_PC + 32'hc4);
        add_entry(squash_word, K_NONE, 0, 0, 0);
        // ld.w, mul.w, csrrd
        add_entry(ri12(10'h0a2, 12'h000, 5'd0, 5'd4), K_ILL, 0, 0, 0);
        add_entry(r3(17'h38, 5'd4, 5'd4, 5'd5), K_ILL, 0, 0, 0);
        add_entry(32'h0400_0006, K_ILL, 0, 0, 0);
        add_entry(r3(17'h2b, 5'd5, 5'd4, 5'd16), K_WB, 5'd16, 32'hffff_f70b, 0);
        add_entry(r3(17'h20, 5'd20, 5'd6, 5'd17), K_WB, 5'd17, 32'h8000_1000, 0);
        add_entry(ri12(10'h00a, 12'h005, 5'd4, 5'd0), K_NONE, 0, 0, 0);
        add_entry(r3(17'h20, 5'd5, 5'd0, 5'd18), K_WB, 5'd18, 32'h0000_08f0, 0);
        add_entry(r3(17'h28, 5'd0, 5'd4, 5'd19), K_WB, 5'd19, 32'h4, 0);
        add_entry(r3(17'h2e, 5'd19, 5'd5, 5'd21), K_WB, 5'd21, 32'h0000_8f00, 0);
        add_entry(r3(17'h2f, 5'd19, 5'd6, 5'd22), K_WB, 5'd22, 32'h0800_0100, 0);
        add_entry(r3(17'h30, 5'd19, 5'd6, 5'd23), K_WB, 5'd23, 32'hf800_0100, 0);
        add_entry(ri12(10'h008, 12'hffc, 5'd4, 5'd24), K_WB, 5'd24, 32'h1, 0);
        add_entry(ri12(10'h009, 12'hffc, 5'd4, 5'd25), K_WB, 5'd25, 32'h1, 0);
        add_entry(ri12(10'h00d, 12'hf0f, 5'd4, 5'd26), K_WB, 5'd26, 32'h0000_0f0b, 0);
        add_entry(ri12(10'h00f, 12'h00f, 5'd4, 5'd27), K_WB, 5'd27, 32'hffff_fff4, 0);
        add_entry(r3(17'h29, 5'd26, 5'd27, 5'd28), K_WB, 5'd28, 32'h0000_0f00, 0);
    endtask

    //////////////////////////////////////////////////
    // result checks
    //////////////////////////////////////////////////

    task automatic check_wb(input logic exp_valid, input la_pkg::reg_idx_t exp_rd,
                            input la_pkg::xlen_t exp_data);
        if (o_wb_valid !== exp_valid) begin
            $display("CHECK FAILED at %0t: wb_valid %b, expected %b", $time, o_wb_valid,
                     exp_valid);
            check_errors++;
        end else if (exp_valid && (o_wb_rd !== exp_rd || o_wb_data !== exp_data)) begin
            $display("CHECK FAILED at %0t: wb r%0d = %h, expected r%0d = %h", $time,
                     o_wb_rd, o_wb_data, exp_rd, exp_data);
            check_errors++;
        end
    endtask

    task automatic check_redirect(input logic exp_valid, input la_pkg::xlen_t exp_target);
        if (o_redirect !== exp_valid) begin
            $display("CHECK FAILED at %0t: redirect %b, expected %b", $time, o_redirect,
                     exp_valid);
            check_errors++;
        end else if (exp_valid && o_redirect_pc !== exp_target) begin
            $display("CHECK FAILED at %0t: redirect pc %h, expected %h", $time,
                     o_redirect_pc, exp_target);
            check_errors++;
        end
    endtask

    task automatic check_illegal(input logic exp_valid);
        if (o_illegal !== exp_valid) begin
            $display("CHECK FAILED at %0t: illegal %b, expected %b", $time, o_illegal,
                     exp_valid);
            check_errors++;
        end
    endtask

    // run guard
    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            timeout_errors++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int kind;
        i_clk          = 1'b0;
        i_reset        = 1'b1;
        i_valid        = 1'b0;
        i_inst         = '0;
        i_pc           = '0;
        check_errors   = 0;
        timeout_errors = 0;
        cycles         = 0;
        build_table();
        cycle_limit = 5 + n_entries + 20;
        repeat (5) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        // entry k goes in while entry k-1 shows its result
        for (int k = 0; k <= n_entries; k++) begin
            if (k > 0) begin
                @(posedge i_clk);
                #2;
            end
            if (k < n_entries) begin
                i_valid = 1'b1;
                i_inst  = tbl_inst[k];
                i_pc    = tbl_pc[k];
            end else begin
                i_valid = 1'b0;
                i_inst  = '0;
            end
            #37;
            kind = (k == 0) ? K_NONE : tbl_kind[k - 1];
            check_wb(kind == K_WB || kind == K_LINK, (k == 0) ? '0 : tbl_rd[k - 1],
                     (k == 0) ? '0 : tbl_data[k - 1]);
            check_redirect(kind == K_BR || kind == K_LINK, (k == 0) ? '0 : tbl_target[k - 1]);
            check_illegal(kind == K_ILL);
        end
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/la_pkg.sv
source/ex_bus_if.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/pipe_ctrl.sv
source/exec_unit.sv
source/la_core_top.sv
bench/la_core_sva.sv
bench/la_core_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module la_core_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module la_core_tb \
		--Mdir $(OBJ_DIR) -o la_core_sim
	./$(OBJ_DIR)/la_core_sim | tee /dev/stderr | grep "TEST OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
